// File: hw/div_defs.svh
/*
 * divider width and bit position macros
 * working values hold guard bits, data bits and extension bits
 */
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// dividend, divisor and quotient width
`define DIV_IN_W    16
// fraction bits of all three
`define DIV_FRAC_W  14

// headroom above the data
`define DIV_GUARD_W 3
// extra precision below the data
`define DIV_EXT_W   8
`define DIV_WORK_W  (`DIV_GUARD_W + `DIV_IN_W + `DIV_EXT_W)

// weight of 1.0 in a working value
`define DIV_ONE_POS (`DIV_EXT_W + `DIV_FRAC_W)

// scale table select width
`define DIV_IDX_W   4

`endif

// File: hw/div_pkg.sv
/*
 * divider types
 * input, working and table index vectors plus the phase encoding
 */
`default_nettype none

`include "div_defs.svh"

package div_pkg;

    // S1.14 dividend and quotient
    typedef logic signed [`DIV_IN_W-1:0] div_in_t;

    // 2.14 divisor
    typedef logic [`DIV_IN_W-1:0] div_den_in_t;

    // working numerator keeps its sign
    typedef logic signed [`DIV_WORK_W-1:0] work_num_t;

    // working denominator is never negative
    typedef logic [`DIV_WORK_W-1:0] work_den_t;

    typedef logic [`DIV_IDX_W-1:0] scale_idx_t;

    // one operation walks through all four in order
    typedef enum logic [1:0] {
        PH_LOAD   = 2'd0,
        PH_COARSE = 2'd1,
        PH_FINE   = 2'd2,
        PH_DONE   = 2'd3
    } div_phase_t;

endpackage

`default_nettype wire

// File: hw/div_phase_ctrl.sv
/*
 * divider phase control
 * steps load, coarse, fine and done once per enabled edge
 */
`timescale 1ns/100ps
`default_nettype none

module div_phase_ctrl
    import div_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst,
    input  wire        en,
    output div_phase_t phase,
    output logic       done
);

    div_phase_t phase_nxt;

    // fixed sequence
    always_comb begin
        case (phase)
            PH_LOAD: begin
                phase_nxt = PH_COARSE;
            end
            PH_COARSE: begin
                phase_nxt = PH_FINE;
            end
            PH_FINE: begin
                phase_nxt = PH_DONE;
            end
            default: begin
                // back to load for the next operation
                phase_nxt = PH_LOAD;
            end
        endcase
    end

    // en low freezes the sequence
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            phase <= PH_LOAD;
        end else if (en) begin
            phase <= phase_nxt;
        end
    end

    // level for the whole done phase
    assign done = (phase == PH_DONE);

endmodule

`default_nettype wire

// File: hw/div_normalizer.sv
/*
 * divider input normalizer
 * moves the divisor leading one onto 1.0 and shifts the dividend to match
 */
`timescale 1ns/100ps
`default_nettype none

`include "div_defs.svh"

module div_normalizer
    import div_pkg::*;
(
    input  wire div_in_t     a,
    input  wire div_den_in_t b,
    output work_num_t        norm_num,
    output work_den_t        norm_den
);

    localparam int LEAD_W = $clog2(`DIV_IN_W);

    work_num_t         ext_num;
    work_den_t         ext_den;
    logic [LEAD_W-1:0] lead;

    // both inputs onto the working grid
    // sign copies into the guard bits for a
    assign ext_num = {{`DIV_GUARD_W{a[`DIV_IN_W-1]}}, a, {`DIV_EXT_W{1'b0}}};
    assign ext_den = {{`DIV_GUARD_W{1'b0}}, b, {`DIV_EXT_W{1'b0}}};

    // leading one search
    // upward scan so the highest set bit wins
    // zero divisor falls back to no shift
    always_comb begin
        lead = LEAD_W'(`DIV_FRAC_W);
        for (int i = 0; i < `DIV_IN_W; i++) begin
            if (b[i]) begin
                lead = LEAD_W'(i);
            end
        end
    end

    // same shift on both keeps the ratio
    always_comb begin
        if (lead > LEAD_W'(`DIV_FRAC_W)) begin
            // only the 2.0 bit sits above 1.0
            norm_num = ext_num >>> 1;
            norm_den = ext_den >> 1;
        end else begin
            // plain left shift for num too
            // out-of-range quotients just wrap
            norm_num = ext_num << (`DIV_FRAC_W - lead);
            norm_den = ext_den << (`DIV_FRAC_W - lead);
        end
    end

endmodule

`default_nettype wire

// File: hw/div_coarse_scale.sv
/*
 * divider coarse scale step
 * multiplies both operands by a shift-add factor near 1/den
 * leaves den within 2^-4 of 1.0
 */
`timescale 1ns/100ps
`default_nettype none

`include "div_defs.svh"

module div_coarse_scale
    import div_pkg::*;
(
    input  wire work_num_t num_q,
    input  wire work_den_t den_q,
    output work_num_t      coarse_num,
    output work_den_t      coarse_den
);

    scale_idx_t idx;
    work_num_t  adj_num;
    work_num_t  adj_den;

    // (factor - 1) * x for the sixteenth of [1,2) that den sits in
    // every row aims at the reciprocal of the interval middle
    function automatic work_num_t coarse_adj(input work_num_t x, input scale_idx_t sel);
        case (sel)
            4'd0:  coarse_adj = '0;
            4'd1:  coarse_adj = -(x >>> 4) - (x >>> 6) - (x >>> 7);
            4'd2:  coarse_adj = -(x >>> 3) - (x >>> 7) - (x >>> 9);
            4'd3:  coarse_adj = -(x >>> 2) + (x >>> 4) + (x >>> 7);
            4'd4:  coarse_adj = -(x >>> 2) + (x >>> 5);
            4'd5:  coarse_adj = -(x >>> 2) - (x >>> 7) + (x >>> 9);
            4'd6:  coarse_adj = -(x >>> 2) - (x >>> 5) - (x >>> 7);
            4'd7:  coarse_adj = -(x >>> 2) - (x >>> 4) - (x >>> 7);
            4'd8:  coarse_adj = -(x >>> 2) - (x >>> 4) - (x >>> 5);
            4'd9:  coarse_adj = -(x >>> 2) - (x >>> 3) + (x >>> 9);
            4'd10: coarse_adj = -(x >>> 2) - (x >>> 3) - (x >>> 6);
            4'd11: coarse_adj = -(x >>> 1) + (x >>> 4) + (x >>> 6);
            4'd12: coarse_adj = -(x >>> 1) + (x >>> 4);
            4'd13: coarse_adj = -(x >>> 1) + (x >>> 5) + (x >>> 7);
            4'd14: coarse_adj = -(x >>> 1) + (x >>> 6) + (x >>> 7);
            4'd15: coarse_adj = -(x >>> 1) + (x >>> 7);
        endcase
    endfunction

    // four bits right under the leading one
    assign idx = den_q[`DIV_ONE_POS-1 -: `DIV_IDX_W];

    // den has a clear top bit so the signed view is safe
    assign adj_num = coarse_adj(num_q, idx);
    assign adj_den = coarse_adj(work_num_t'(den_q), idx);

    assign coarse_num = num_q + adj_num;
    // adjustment is zero or negative, modulo add gives the difference
    assign coarse_den = den_q + work_den_t'(adj_den);

endmodule

`default_nettype wire

// File: hw/div_fine_scale.sv
/*
 * divider fine scale step
 * corrects the remaining deviation of den from 1.0 with a second factor
 * leaves den within 2^-8 of 1.0
 */
`timescale 1ns/100ps
`default_nettype none

`include "div_defs.svh"

module div_fine_scale
    import div_pkg::*;
(
    input  wire work_num_t num_q,
    input  wire work_den_t den_q,
    output work_num_t      fine_num,
    output work_den_t      fine_den
);

    // index msb four places under 1.0
    localparam int        FINE_TOP = `DIV_ONE_POS - `DIV_IDX_W;
    localparam work_den_t ONE      = work_den_t'(1) << `DIV_ONE_POS;
    // half an index step so the rows are centred on k/128
    localparam work_den_t RND      = work_den_t'(1) << (FINE_TOP - `DIV_IDX_W);

    logic       below;
    work_den_t  dev;
    work_den_t  dev_rnd;
    scale_idx_t idx;
    work_num_t  delta_num;
    work_num_t  delta_den;

    // |factor - 1| * x for deviation k/128
    // above 1.0 needs k/(128+k), below 1.0 needs k/(128-k)
    function automatic work_num_t fine_delta(input work_num_t x, input scale_idx_t sel,
                                             input logic neg);
        if (!neg) begin
            case (sel)
                4'd0:  fine_delta = '0;
                4'd1:  fine_delta = x >>> 7;
                4'd2:  fine_delta = (x >>> 6) - (x >>> 12);
                4'd3:  fine_delta = (x >>> 6) + (x >>> 7) - (x >>> 11);
                4'd4:  fine_delta = (x >>> 5) - (x >>> 10);
                4'd5:  fine_delta = (x >>> 5) + (x >>> 8) + (x >>> 9) + (x >>> 11);
                4'd6:  fine_delta = (x >>> 5) + (x >>> 6) - (x >>> 9) - (x >>> 13);
                4'd7:  fine_delta = (x >>> 5) + (x >>> 6) + (x >>> 8) + (x >>> 10);
                4'd8:  fine_delta = (x >>> 4) - (x >>> 8) + (x >>> 12);
                4'd9:  fine_delta = (x >>> 4) + (x >>> 9) + (x >>> 10) + (x >>> 12);
                4'd10: fine_delta = (x >>> 4) + (x >>> 7) + (x >>> 9) + (x >>> 12);
                4'd11: fine_delta = (x >>> 4) + (x >>> 6) + (x >>> 10);
                4'd12: fine_delta = (x >>> 4) + (x >>> 6) + (x >>> 7) - (x >>> 12);
                4'd13: fine_delta = (x >>> 4) + (x >>> 5) - (x >>> 10) - (x >>> 11);
                4'd14: fine_delta = (x >>> 4) + (x >>> 5) + (x >>> 8) + (x >>> 10);
                4'd15: fine_delta = (x >>> 3) - (x >>> 6) - (x >>> 8) - (x >>> 11);
            endcase
        end else begin
            case (sel)
                4'd0:  fine_delta = '0;
                4'd1:  fine_delta = x >>> 7;
                4'd2:  fine_delta = (x >>> 6) + (x >>> 12);
                4'd3:  fine_delta = (x >>> 6) + (x >>> 7) + (x >>> 11);
                4'd4:  fine_delta = (x >>> 5) + (x >>> 10);
                4'd5:  fine_delta = (x >>> 5) + (x >>> 7) + (x >>> 10) + (x >>> 11);
                4'd6:  fine_delta = (x >>> 5) + (x >>> 6) + (x >>> 9) + (x >>> 12);
                4'd7:  fine_delta = (x >>> 4) - (x >>> 8) - (x >>> 11) - (x >>> 12);
                4'd8:  fine_delta = (x >>> 4) + (x >>> 8) + (x >>> 12);
                4'd9:  fine_delta = (x >>> 4) + (x >>> 6) - (x >>> 9) - (x >>> 11);
                4'd10: fine_delta = (x >>> 4) + (x >>> 5) - (x >>> 7) - (x >>> 10);
                4'd11: fine_delta = (x >>> 4) + (x >>> 5) + (x >>> 12);
                4'd12: fine_delta = (x >>> 4) + (x >>> 5) + (x >>> 7) + (x >>> 9);
                4'd13: fine_delta = (x >>> 3) - (x >>> 7) - (x >>> 8) - (x >>> 12);
                4'd14: fine_delta = (x >>> 3) - (x >>> 9) - (x >>> 12);
                4'd15: fine_delta = (x >>> 3) + (x >>> 7);
            endcase
        end
    endfunction

    // den just under 1.0 has the 1.0 bit clear
    assign below = ~den_q[`DIV_ONE_POS];

    // magnitude of the deviation from 1.0
    assign dev     = below ? (ONE - den_q) : (den_q - ONE);
    assign dev_rnd = dev + RND;
    // exact 1.0 lands on row 0
    assign idx     = dev_rnd[FINE_TOP -: `DIV_IDX_W];

    assign delta_num = fine_delta(num_q, idx, below);
    assign delta_den = fine_delta(work_num_t'(den_q), idx, below);

    // grow when below 1.0 and shrink when above
    assign fine_num = below ? (num_q + delta_num) : (num_q - delta_num);
    assign fine_den = below ? (den_q + work_den_t'(delta_den))
                            : (den_q - work_den_t'(delta_den));

endmodule

`default_nettype wire

// File: hw/div_operand_regs.sv
/*
 * divider working registers
 * numerator and denominator updated once per phase
 * the quotient is read straight from the numerator
 */
`timescale 1ns/100ps
`default_nettype none

`include "div_defs.svh"

module div_operand_regs
    import div_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             en,
    input  wire div_phase_t phase,
    input  wire work_num_t  norm_num,
    input  wire work_den_t  norm_den,
    input  wire work_num_t  coarse_num,
    input  wire work_den_t  coarse_den,
    input  wire work_num_t  fine_num,
    input  wire work_den_t  fine_den,
    output work_num_t       num_q,
    output work_den_t       den_q,
    output div_in_t         result
);

    work_num_t num_nxt;
    work_den_t den_nxt;

    // next value picked by phase
    always_comb begin
        case (phase)
            PH_LOAD: begin
                num_nxt = norm_num;
                den_nxt = norm_den;
            end
            PH_COARSE: begin
                num_nxt = coarse_num;
                den_nxt = coarse_den;
            end
            PH_FINE: begin
                num_nxt = fine_num;
                den_nxt = fine_den;
            end
            default: begin
                // done holds the quotient
                num_nxt = num_q;
                den_nxt = den_q;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            num_q <= '0;
            den_q <= '0;
        end else if (en) begin
            num_q <= num_nxt;
            den_q <= den_nxt;
        end
    end

    // den is ~1.0 by now so num is the quotient
    assign result = num_q[`DIV_EXT_W +: `DIV_IN_W];

endmodule

`default_nettype wire

// File: hw/div_top.sv
/*
 * goldschmidt style fixed-point divider
 * S1.14 dividend over 2.14 divisor in four enabled phases
 */
`timescale 1ns/100ps
`default_nettype none

module div_top
    import div_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire              en,
    input  wire div_in_t     a,
    input  wire div_den_in_t b,
    output logic             done,
    output div_in_t          result
);

    div_phase_t phase;

    // phase 0 candidates
    work_num_t norm_num;
    work_den_t norm_den;

    // registered operands feeding both scale steps
    work_num_t num_q;
    work_den_t den_q;

    // phase 1 and phase 2 candidates
    work_num_t coarse_num;
    work_den_t coarse_den;
    work_num_t fine_num;
    work_den_t fine_den;

    div_phase_ctrl u_phase_ctrl (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .en    (en),
        .phase (phase),
        .done  (done)
    );

    // a and b are taken when the load phase registers
    div_normalizer u_normalizer (
        .a        (a),
        .b        (b),
        .norm_num (norm_num),
        .norm_den (norm_den)
    );

    div_coarse_scale u_coarse_scale (
        .num_q      (num_q),
        .den_q      (den_q),
        .coarse_num (coarse_num),
        .coarse_den (coarse_den)
    );

    div_fine_scale u_fine_scale (
        .num_q    (num_q),
        .den_q    (den_q),
        .fine_num (fine_num),
        .fine_den (fine_den)
    );

    div_operand_regs u_operand_regs (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .en         (en),
        .phase      (phase),
        .norm_num   (norm_num),
        .norm_den   (norm_den),
        .coarse_num (coarse_num),
        .coarse_den (coarse_den),
        .fine_num   (fine_num),
        .fine_den   (fine_den),
        .num_q      (num_q),
        .den_q      (den_q),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: verif/div_chk.sv
/*
 * divider protocol checks
 * done level and phase cadence, bound into the top level
 */
`timescale 1ns/100ps
`default_nettype none

module div_chk (
    input wire i_clk,
    input wire i_rst,
    input wire en,
    input wire done
);

    // enabled edges since the last done phase
    logic [2:0] en_cnt;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            en_cnt <= '0;
        end else if (en) begin
            if (done) begin
                en_cnt <= '0;
            end else begin
                en_cnt <= en_cnt + 3'd1;
            end
        end
    end

    // reset leaves the phase in load
    done_low_after_reset: assert property (@(posedge i_clk) i_rst |=> !done)
        else $error("done high right after reset");

    // done lasts exactly one enabled edge
    no_double_done: assert property (@(posedge i_clk) disable iff (i_rst)
        (en && done) |=> !done)
        else $error("done high on two enabled edges in a row");

    // load, coarse and fine between two done phases
    three_edge_gap: assert property (@(posedge i_clk) disable iff (i_rst)
        (en && done) |-> (en_cnt == 3'd3))
        else $error("done reached after the wrong number of enabled edges");

    done_after_three: assert property (@(posedge i_clk) disable iff (i_rst)
        (en_cnt == 3'd3) |-> done)
        else $error("done missing after three enabled edges");

endmodule

bind div_top div_chk u_chk (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .en    (en),
    .done  (done)
);

`default_nettype wire

// File: verif/div_tb.sv
/*
 * divider testbench
 * random operands under a random en strobe, checked against a real-valued model
 */
`timescale 1ns/100ps
`default_nettype none

`include "div_defs.svh"

module div_tb
    import div_pkg::*;
();

    localparam int  NUM_OPS         = 400;
    localparam int  CLK_HALF        = 50;
    localparam int  RST_CYCLES      = 8;
    localparam int  QUOT_TOL        = 128;
    // four phases per op, en gaps at most double it
    localparam int  WATCHDOG_CYCLES = NUM_OPS * 4 * 2 + RST_CYCLES + 200;
    localparam real Q_SCALE         = real'(1 << `DIV_FRAC_W);

    logic        i_clk = 1'b0;
    logic        i_rst = 1'b1;
    logic        en    = 1'b0;
    // first op is 0 / 1.0
    div_in_t     a     = '0;
    div_den_in_t b     = div_den_in_t'(1 << `DIV_FRAC_W);
    logic        done;
    div_in_t     result;

    logic [31:0] rng_state  = 32'h3942_a144;
    logic        cur_pow2   = 1'b1;
    int unsigned ops_picked = 1;
    int unsigned ops_checked = 0;

    // model of the op in flight
    logic [1:0]  m_phase = 2'd0;
    div_in_t     m_a     = '0;
    div_den_in_t m_b     = div_den_in_t'(1);
    logic        m_pow2  = 1'b1;

    div_top u_div_top (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .en     (en),
        .a      (a),
        .b      (b),
        .done   (done),
        .result (result)
    );

    always #(CLK_HALF) i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // every fourth op a power-of-two divisor, every fourth a negative dividend
    // |a/b| kept under 1.9 so the quotient fits S1.14
    task automatic pick_operands(input int unsigned idx, output div_in_t na,
                                 output div_den_in_t nb, output logic pow2);
        logic [31:0] r;
        int          lim;
        int          rv;
        int          av;
        r    = rand_next();
        pow2 = (idx % 4 == 0);
        if (pow2) begin
            nb = div_den_in_t'(1) << r[3:0];
        end else begin
            nb = r[15:0];
            if (nb == '0) begin
                nb = div_den_in_t'(1);
            end
        end
        lim = (19 * int'(nb) - 1) / 10;
        if (lim > 32767) begin
            lim = 32767;
        end
        r  = rand_next();
        rv = int'({1'b0, r[30:0]});
        av = rv % (2 * lim + 1) - lim;
        if (idx % 4 == 2 && av > 0) begin
            av = -av;
        end
        na = div_in_t'(av);
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: done is %b, expected %b", $time, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "done level mismatch");
        end
    endtask

    // a small quotient could flip sign inside the tolerance
    task automatic check_quot(input div_in_t got, input real exp_q, input int tol);
        real diff;
        diff = real'(got) - exp_q;
        if (diff < 0.0) begin
            diff = -diff;
        end
        if (diff > real'(tol)) begin
            $display("FAILED at %0t: result %0d for %0d / %0d, expected %0.2f within %0d",
                     $time, got, m_a, m_b, exp_q, tol);
            $display("*** FAILED ***");
            $fatal(1, "quotient out of tolerance");
        end
        // sign of the result must follow the exact quotient
        if ((exp_q < 0.0 && got > 0) || (exp_q > 0.0 && got < 0)) begin
            $display("FAILED at %0t: result %0d for %0d / %0d has the wrong sign",
                     $time, got, m_a, m_b);
            $display("*** FAILED ***");
            $fatal(1, "quotient sign wrong");
        end
    endtask

    // model update reads the inputs before this edge changes them
    always @(posedge i_clk) begin
        logic [31:0] r;
        div_in_t     na;
        div_den_in_t nb;
        logic        np;
        r = rand_next();
        if (i_rst) begin
            m_phase <= 2'd0;
        end else if (en) begin
            if (m_phase == 2'd0) begin
                m_a    <= a;
                m_b    <= b;
                m_pow2 <= cur_pow2;
            end
            // leaving done, next operands ready before the load edge
            if (m_phase == 2'd3) begin
                ops_checked <= ops_checked + 1;
                pick_operands(ops_picked, na, nb, np);
                ops_picked <= ops_picked + 1;
                a          <= na;
                b          <= nb;
                cur_pow2   <= np;
            end
            m_phase <= m_phase + 2'd1;
        end
        // en high three cycles in four
        en <= (r[1:0] != 2'b00);
    end

    // outputs settle well before the falling edge
    always @(negedge i_clk) begin
        real q;
        if (i_rst) begin
            check_done(done, 1'b0);
        end else begin
            check_done(done, m_phase == 2'd3);
            // every cycle of done, so en gaps check the hold too
            if (m_phase == 2'd3) begin
                q = real'(m_a) * Q_SCALE / real'(m_b);
                if (m_pow2) begin
                    check_quot(result, $floor(q), 0);
                end else begin
                    check_quot(result, q, QUOT_TOL);
                end
            end
        end
    end

    initial begin
        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        wait (ops_checked == NUM_OPS);
        @(negedge i_clk);
        $display("*** PASSED ***");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("timeout with %0d of %0d operations done", ops_checked, NUM_OPS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: div_top.f
+incdir+hw
hw/div_pkg.sv
hw/div_phase_ctrl.sv
hw/div_normalizer.sv
hw/div_coarse_scale.sv
hw/div_fine_scale.sv
hw/div_operand_regs.sv
hw/div_top.sv
verif/div_chk.sv
verif/div_tb.sv

// File: Makefile
# Verilator lint and simulation of the divider testbench

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = div_tb
FILELIST   = div_top.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = *** PASSED ***
FAIL_MSG   = *** FAILED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
